/* Bender.yml */
package:
  name: fetch_unit

sources:
  - include_dirs:
      - design
    files:
      - design/fetch_pkg.sv
      - design/fetch_req_gen.sv
      - design/seq_num_alloc.sv
      - design/fetch_resp_join.sv
      - design/fetch_unit.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/fetch_mem_model.sv
      - sim/fetch_unit_tb.sv

/* design/fetch_consts.svh */
/*
  Fetch front end constants
  Reset address, tag window and request limits
*/

`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// First address fetched out of reset
`define FETCH_RST_ADDR 32'h0000_0200

// Tag width, window of 2**bits tags
`define FETCH_SEQ_BITS 5

// Commit lanes per cycle
`define FETCH_RECLAIM_WIDTH 2

// Max outstanding memory reads
`define FETCH_MAX_INFLIGHT 4

`endif

/* design/fetch_pkg.sv */
/*
  Fetch front end types
  Memory request and response, decode packet, commit lanes
*/

`include "fetch_consts.svh"

package fetch_pkg;

  // --------------------------------------------------
  // Memory interface
  // --------------------------------------------------

  // Only reads are issued by fetch
  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e     op;
    logic [31:0] addr;
  } mem_req_t;

  // Response echoes op and address
  typedef struct packed {
    mem_op_e     op;
    logic [31:0] addr;
    logic [31:0] data;
  } mem_resp_t;

  // --------------------------------------------------
  // Decode and commit
  // --------------------------------------------------

  typedef struct packed {
    logic [31:0]                pc;
    logic [31:0]                inst;
    logic [`FETCH_SEQ_BITS-1:0] seq_num;
  } fetch_pkt_t;

  // Lane 0 always holds the older commit
  typedef struct packed {
    logic [`FETCH_RECLAIM_WIDTH-1:0]                           val;
    logic [`FETCH_RECLAIM_WIDTH-1:0][`FETCH_SEQ_BITS-1:0] seq_num;
  } commit_t;

endpackage

/* design/fetch_req_gen.sv */
/*
  Fetch request generator
  Issues sequential word reads and caps outstanding requests
*/

`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_req_gen (
  input  logic               clk,
  input  logic               rst,
  output fetch_pkg::mem_req_t mem_req,
  output logic               mem_req_val,
  input  logic               mem_req_rdy,
  input  logic               resp_xfer
);

  import fetch_pkg::*;

  localparam int unsigned MAX_INFLIGHT = `FETCH_MAX_INFLIGHT;
  localparam int unsigned CNT_W        = $clog2(MAX_INFLIGHT + 1);

  logic [31:0]      fetch_addr;
  logic [CNT_W-1:0] inflight;
  logic             req_xfer;

  // --------------------------------------------------
  // Request side
  // --------------------------------------------------

  // Stop issuing once the limit is reached
  assign mem_req_val = (inflight != CNT_W'(MAX_INFLIGHT));
  assign req_xfer    = mem_req_val & mem_req_rdy;

  assign mem_req.op   = mem_read;
  assign mem_req.addr = fetch_addr;

  // Next word address on each accepted request
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_addr <= `FETCH_RST_ADDR;
    end else if (req_xfer) begin
      fetch_addr <= fetch_addr + 32'd4;
    end
  end

  // --------------------------------------------------
  // In-flight counter
  // --------------------------------------------------

  // Up on request, down on response, both cancel
  always_ff @(posedge clk) begin
    if (rst) begin
      inflight <= '0;
    end else begin
      case ({req_xfer, resp_xfer})
        2'b10:   inflight <= inflight + CNT_W'(1);
        2'b01:   inflight <= inflight - CNT_W'(1);
        default: inflight <= inflight;
      endcase
    end
  end

endmodule

/* design/fetch_resp_join.sv */
/*
  Response join
  Pairs a memory response with a fresh tag into the decode register
*/

`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_resp_join (
  input  logic                       clk,
  input  logic                       rst,
  input  fetch_pkg::mem_resp_t       mem_resp,
  input  logic                       mem_resp_val,
  output logic                       mem_resp_rdy,
  input  logic                       alloc_val,
  input  logic [`FETCH_SEQ_BITS-1:0] alloc_seq_num,
  output logic                       alloc_take,
  output logic                       resp_xfer,
  output fetch_pkg::fetch_pkt_t      d_pkt,
  output logic                       d_val,
  input  logic                       d_rdy
);

  import fetch_pkg::*;

  fetch_pkt_t pkt_next;
  logic       accept;

  // --------------------------------------------------
  // Accept
  // --------------------------------------------------

  // Needs a tag and a free or draining output slot
  assign mem_resp_rdy = alloc_val & (~d_val | d_rdy);
  assign accept       = mem_resp_val & mem_resp_rdy;

  // Same event toward allocator and request side
  assign alloc_take = accept;
  assign resp_xfer  = accept;

  // Response op is always a read here
  assign pkt_next.pc      = mem_resp.addr;
  assign pkt_next.inst    = mem_resp.data;
  assign pkt_next.seq_num = alloc_seq_num;

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      d_val <= 1'b0;
    end else if (accept) begin
      d_val <= 1'b1;
    end else if (d_rdy) begin
      d_val <= 1'b0;
    end
  end

  // Payload, held while stalled
  always_ff @(posedge clk) begin
    if (accept) begin
      d_pkt <= pkt_next;
    end
  end

endmodule

/* design/fetch_unit.sv */
/*
  Fetch unit top level
  Request generator, tag allocator and response join
*/

`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,
  // Memory request
  output fetch_pkg::mem_req_t   mem_req,
  output logic                  mem_req_val,
  input  logic                  mem_req_rdy,
  // Memory response
  input  fetch_pkg::mem_resp_t  mem_resp,
  input  logic                  mem_resp_val,
  output logic                  mem_resp_rdy,
  // Decode
  output fetch_pkg::fetch_pkt_t d_pkt,
  output logic                  d_val,
  input  logic                  d_rdy,
  // Commit notify
  input  fetch_pkg::commit_t    commit
);

  logic                       resp_xfer;
  logic                       alloc_val;
  logic                       alloc_take;
  logic [`FETCH_SEQ_BITS-1:0] alloc_seq_num;

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------

  fetch_req_gen req_gen (
    .clk         (clk),
    .rst         (rst),
    .mem_req     (mem_req),
    .mem_req_val (mem_req_val),
    .mem_req_rdy (mem_req_rdy),
    .resp_xfer   (resp_xfer)
  );

  seq_num_alloc seq_alloc (
    .clk           (clk),
    .rst           (rst),
    .alloc_val     (alloc_val),
    .alloc_seq_num (alloc_seq_num),
    .alloc_take    (alloc_take),
    .commit        (commit)
  );

  fetch_resp_join resp_join (
    .clk           (clk),
    .rst           (rst),
    .mem_resp      (mem_resp),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .alloc_val     (alloc_val),
    .alloc_seq_num (alloc_seq_num),
    .alloc_take    (alloc_take),
    .resp_xfer     (resp_xfer),
    .d_pkt         (d_pkt),
    .d_val         (d_val),
    .d_rdy         (d_rdy)
  );

endmodule

/* design/seq_num_alloc.sv */
/*
  Sequence number allocator
  Circular tag window, one tag out per cycle, up to two reclaimed
*/

`timescale 1ns/1ps

`include "fetch_consts.svh"

module seq_num_alloc (
  input  logic                       clk,
  input  logic                       rst,
  output logic                       alloc_val,
  output logic [`FETCH_SEQ_BITS-1:0] alloc_seq_num,
  input  logic                       alloc_take,
  input  fetch_pkg::commit_t         commit
);

  localparam int unsigned SEQ_BITS = `FETCH_SEQ_BITS;
  localparam int unsigned LANES    = `FETCH_RECLAIM_WIDTH;
  // Extra wrap bit on each pointer
  localparam int unsigned PTR_W    = SEQ_BITS + 1;
  localparam int unsigned CNT_W    = $clog2(LANES + 1);
  localparam int unsigned WINDOW   = 1 << SEQ_BITS;

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] head_next;
  logic [PTR_W-1:0] tail_next;
  logic [PTR_W-1:0] used_next;
  logic [CNT_W-1:0] commit_cnt;

  // --------------------------------------------------
  // Reclaim count
  // --------------------------------------------------

  // Commits are in order, so only the number of
  // valid lanes matters, not the tags they carry
  always_comb begin
    commit_cnt = '0;
    for (int i = 0; i < LANES; i++) begin
      commit_cnt = commit_cnt + CNT_W'(commit.val[i]);
    end
  end

  // --------------------------------------------------
  // Pointers
  // --------------------------------------------------

  assign tail_next = tail + PTR_W'(alloc_take);
  assign head_next = head + PTR_W'(commit_cnt);

  // Tags in use after this edge
  assign used_next = tail_next - head_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
    end else begin
      head <= head_next;
      tail <= tail_next;
    end
  end

  // Registered full check on next pointers, so a tag
  // freed now is offered next cycle. Held off in reset
  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_val <= 1'b0;
    end else begin
      alloc_val <= (used_next != PTR_W'(WINDOW));
    end
  end

  // Low bits of tail name the next tag
  assign alloc_seq_num = tail[SEQ_BITS-1:0];

endmodule

/* fetch_unit.f */
+incdir+design
design/fetch_pkg.sv
design/fetch_req_gen.sv
design/seq_num_alloc.sv
design/fetch_resp_join.sv
design/fetch_unit.sv
sim/fetch_mem_model.sv
sim/fetch_unit_tb.sv

/* sim/fetch_input.txt */
// Header words: window fill count, count after one commit, total count, image pairs
// Then one line per image word: address, instruction word (all hex)
00000020 00000001 00000060 00000018
00000200 00000093
00000204 00100113
00000208 00200193
0000020c 00300213
00000210 002081b3
00000214 40110233
00000218 0020f2b3
0000021c 0020e333
00000220 0020c3b3
00000224 00209433
00000228 0020d4b3
0000022c 4020d533
00000230 00a00593
00000234 00b02023
00000238 00002603
0000023c 00c58633
00000240 fff60613
00000244 00161693
00000248 0016d713
0000024c 00e687b3
00000250 00f02223
00000254 00402803
00000258 01078833
0000025c 00000013

/* sim/fetch_mem_model.sv */
/*
  Instruction memory model for the fetch testbench
  Answers reads in order with random latency and request stalls
*/

`timescale 1ns/1ps

module fetch_mem_model (
  input  logic                 clk,
  input  logic                 rst,
  input  fetch_pkg::mem_req_t  mem_req,
  input  logic                 mem_req_val,
  output logic                 mem_req_rdy,
  output fetch_pkg::mem_resp_t mem_resp,
  output logic                 mem_resp_val,
  input  logic                 mem_resp_rdy
);

  import fetch_pkg::*;

  // Words 0-3 of the file are counts, pairs follow
  localparam int HDR = 4;

  logic [31:0] file_data [0:127];
  mem_resp_t   pend_q [$];
  int unsigned due_q [$];
  int unsigned cycle;
  mem_resp_t   resp_new;

  initial begin
    $readmemh("sim/fetch_input.txt", file_data);
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
  end

  // Image word if listed, else a pattern of the full address
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] word;
    word = addr ^ 32'h5a5a_a5a5;
    for (int i = 0; i < int'(file_data[3]); i++) begin
      if (file_data[HDR + 2 * i] == addr) begin
        word = file_data[HDR + 2 * i + 1];
      end
    end
    return word;
  endfunction

  // --------------------------------------------------
  // In-order pipe with 1 to 4 cycles latency
  // --------------------------------------------------

  always @(posedge clk) begin
    if (rst) begin
      pend_q.delete();
      due_q.delete();
      cycle = 0;
      mem_req_rdy  <= 1'b0;
      mem_resp_val <= 1'b0;
    end else begin
      cycle = cycle + 1;
      // Retire the response taken on this edge
      if (mem_resp_val && mem_resp_rdy) begin
        void'(pend_q.pop_front());
        void'(due_q.pop_front());
      end
      if (mem_req_val && mem_req_rdy) begin
        resp_new.op   = mem_read;
        resp_new.addr = mem_req.addr;
        resp_new.data = read_word(mem_req.addr);
        pend_q.push_back(resp_new);
        due_q.push_back(cycle + 1 + ($urandom % 4));
      end
      // Stall roughly one cycle in four
      mem_req_rdy <= ($urandom % 4) != 0;
      // Oldest entry shown once its latency is up
      if (pend_q.size() > 0 && due_q[0] <= cycle) begin
        mem_resp     <= pend_q[0];
        mem_resp_val <= 1'b1;
      end else begin
        mem_resp_val <= 1'b0;
      end
    end
  end

endmodule

/* sim/fetch_unit_tb.sv */
/*
  Fetch unit testbench
  Clock, reset, decode back-pressure, commits and scoreboard
*/

`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_unit_tb;

  import fetch_pkg::*;

  localparam int HDR    = 4;
  localparam int WINDOW = 1 << `FETCH_SEQ_BITS;

  logic       clk;
  logic       rst;
  mem_req_t   mem_req;
  logic       mem_req_val;
  logic       mem_req_rdy;
  mem_resp_t  mem_resp;
  logic       mem_resp_val;
  logic       mem_resp_rdy;
  fetch_pkt_t d_pkt;
  logic       d_val;
  logic       d_rdy;
  commit_t    commit;

  logic [31:0]                file_data [0:127];
  logic [`FETCH_SEQ_BITS-1:0] tag_q [$];
  logic [31:0]                exp_pc;
  logic [`FETCH_SEQ_BITS-1:0] exp_seq;
  int                         delivered;
  logic                       held;
  fetch_pkt_t                 held_pkt;

  fetch_unit dut (
    .clk          (clk),
    .rst          (rst),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .d_pkt        (d_pkt),
    .d_val        (d_val),
    .d_rdy        (d_rdy),
    .commit       (commit)
  );

  fetch_mem_model mem (
    .clk          (clk),
    .rst          (rst),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic check_val(input string name, input logic [95:0] actual,
                           input logic [95:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Timeout");
  endtask

  // Expected word at a pc from the image or the address pattern
  function automatic logic [31:0] image_word(input logic [31:0] addr);
    logic [31:0] word;
    word = addr ^ 32'h5a5a_a5a5;
    for (int i = 0; i < int'(file_data[3]); i++) begin
      if (file_data[HDR + 2 * i] == addr) begin
        word = file_data[HDR + 2 * i + 1];
      end
    end
    return word;
  endfunction

  // Counters change at negedge, so poll on posedge
  task automatic wait_delivered(input int target, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (delivered < target) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        stop_on_timeout(what);
      end
    end
  endtask

  // --------------------------------------------------
  // Decode monitor and scoreboard
  // --------------------------------------------------

  always @(negedge clk) begin
    if (!rst) begin
      // Fetch only ever reads
      if (mem_req_val && mem_req_rdy) begin
        check_val("mem_req.op", mem_req.op, mem_read);
      end
      // Stalled packet must hold
      if (held) begin
        check_val("d_val", d_val, 1'b1);
        check_val("d_pkt", d_pkt, held_pkt);
      end
      if (d_val && d_rdy) begin
        check_val("d_pkt.pc", d_pkt.pc, exp_pc);
        check_val("d_pkt.inst", d_pkt.inst, image_word(exp_pc));
        check_val("d_pkt.seq_num", d_pkt.seq_num, exp_seq);
        tag_q.push_back(d_pkt.seq_num);
        check_val("outstanding tags in range", tag_q.size() <= WINDOW, 1'b1);
        exp_pc  = exp_pc + 32'd4;
        exp_seq = exp_seq + 1'b1;
        delivered++;
      end
      held     = d_val && !d_rdy;
      held_pkt = d_pkt;
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    int unsigned seed;
    int          cycles;
    int          lanes;
    commit_t     c;

    seed = $urandom(39645);
    $readmemh("sim/fetch_input.txt", file_data);
    clk       = 1'b0;
    rst       = 1'b1;
    d_rdy     = 1'b0;
    commit    = '0;
    exp_pc    = `FETCH_RST_ADDR;
    exp_seq   = '0;
    delivered = 0;
    held      = 1'b0;

    // Outputs stay quiet through two reset edges
    @(posedge clk);
    @(negedge clk);
    check_val("d_val", d_val, 1'b0);
    check_val("mem_resp_rdy", mem_resp_rdy, 1'b0);
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_val("d_val", d_val, 1'b0);
    check_val("mem_resp_rdy", mem_resp_rdy, 1'b0);
    cycles = 0;
    while (!mem_req_val) begin
      @(negedge clk);
      cycles++;
      if (cycles > 20) begin
        stop_on_timeout("first memory request");
      end
    end
    check_val("mem_req.addr", mem_req.addr, `FETCH_RST_ADDR);

    // Fill the tag window with commits held back
    @(posedge clk);
    d_rdy <= 1'b1;
    wait_delivered(file_data[0], 2000, "window fill");
    repeat (50) begin
      @(negedge clk);
      check_val("d_val", d_val, 1'b0);
    end
    check_val("delivered", delivered, WINDOW);

    // One commit frees one tag
    @(posedge clk);
    c = '0;
    c.val[0]     = 1'b1;
    c.seq_num[0] = tag_q.pop_front();
    commit <= c;
    @(posedge clk);
    commit <= '0;
    wait_delivered(file_data[0] + file_data[1], 200, "packet after one commit");

    // Window full again until the next commit
    repeat (50) begin
      @(negedge clk);
      check_val("d_val", d_val, 1'b0);
    end

    // Random back-pressure and 0 to 2 commits per cycle
    cycles = 0;
    while (delivered < file_data[2]) begin
      @(posedge clk);
      d_rdy <= ($urandom % 4) != 0;
      lanes = $urandom % 3;
      c = '0;
      for (int i = 0; i < `FETCH_RECLAIM_WIDTH; i++) begin
        if (i < lanes && tag_q.size() > 0) begin
          c.val[i]     = 1'b1;
          c.seq_num[i] = tag_q.pop_front();
        end
      end
      commit <= c;
      cycles++;
      if (cycles > 5000) begin
        stop_on_timeout("random phase packets");
      end
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
